// ==== rtl/dm_mem_pkg.sv ====
package dm_mem_pkg;

  // ------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------
  localparam int unsigned bus_width     = 32;
  localparam int unsigned dbg_addr_bits = 12;
  localparam int unsigned data_count    = 2;
  localparam int unsigned progbuf_size  = 8;
  // first aarsize that the window cannot serve
  localparam int unsigned max_aar       = 3;

  // index widths into the data registers and program buffer
  localparam int unsigned data_idx_bits    = (data_count > 1) ? $clog2(data_count) : 1;
  localparam int unsigned progbuf_idx_bits = (progbuf_size > 1) ? $clog2(progbuf_size) : 1;

  typedef logic [bus_width-1:0]     word_t;
  typedef logic [dbg_addr_bits-1:0] dbg_addr_t;

  // ------------------------------------------------------------------
  // address map, offsets inside the debug module page
  // ------------------------------------------------------------------
  localparam dbg_addr_t halted_addr       = 'h100;
  localparam dbg_addr_t going_addr        = 'h108;
  localparam dbg_addr_t resuming_addr     = 'h110;
  localparam dbg_addr_t exception_addr    = 'h118;
  localparam dbg_addr_t whereto_addr      = 'h300;
  localparam dbg_addr_t abs_cmd_base_addr = 'h338;
  localparam dbg_addr_t progbuf_base_addr = 'h360;
  localparam dbg_addr_t data_base_addr    = 'h380;
  localparam dbg_addr_t flags_base_addr   = 'h400;
  localparam dbg_addr_t flags_end_addr    = 'h7ff;
  localparam dbg_addr_t resume_addr       = 'h804;

  localparam dbg_addr_t data_end_addr    = dbg_addr_t'(data_base_addr + 4 * data_count - 1);
  localparam dbg_addr_t progbuf_end_addr = dbg_addr_t'(progbuf_base_addr + 4 * progbuf_size - 1);

  // ------------------------------------------------------------------
  // abstract commands
  // ------------------------------------------------------------------
  typedef enum logic [7:0] {
    access_register = 8'h0,
    quick_access    = 8'h1,
    access_memory   = 8'h2
  } cmdtype_e;

  typedef enum logic [2:0] {
    cmd_err_none          = 3'd0,
    cmd_err_not_supported = 3'd2,
    cmd_err_exception     = 3'd3,
    cmd_err_halt_resume   = 3'd4
  } cmderr_e;

  typedef struct packed {
    cmdtype_e    cmdtype;
    logic [23:0] control;
  } command_t;

  // access register view of the control field
  typedef struct packed {
    logic        zero1;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_cmd_t;

  // jal x0 with a signed byte offset, J-type immediate scramble
  function automatic word_t dm_jal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f};
  endfunction

endpackage

// ==== rtl/dm_mem_bus_if.sv ====
`timescale 1ns/1ps

// hart side memory bus, one cycle per request and never stalled
interface dm_mem_bus_if import dm_mem_pkg::*; ();

  logic                   req;
  logic                   we;
  logic [bus_width-1:0]   addr;
  word_t                  wdata;
  // byte lane enables for writes
  logic [bus_width/8-1:0] be;

  // the top level drives the bus
  modport host (
    output req, we, addr, wdata, be
  );

  // decode blocks only observe it
  modport target (
    input req, we, addr, wdata, be
  );

endinterface

// ==== rtl/dm_hart_if.sv ====
`timescale 1ns/1ps

// hart status towards the command FSM
interface dm_hart_if #(
  parameter int unsigned nr_harts = 2
) ();

  // registered per hart state
  logic [nr_harts-1:0] halted;
  logic [nr_harts-1:0] resuming;
  // pulses in the cycle of the matching write
  logic [nr_harts-1:0] halted_evt;
  logic                going;
  logic                exception;

  modport status (
    output halted, resuming, halted_evt, going, exception
  );

  modport ctrl (
    input halted, resuming, halted_evt, going, exception
  );

endinterface

// ==== rtl/dm_cmd_fsm.sv ====
`timescale 1ns/1ps

module dm_cmd_fsm import dm_mem_pkg::*; #(
  parameter int unsigned  nr_harts  = 2,
  localparam int unsigned hart_bits = (nr_harts > 1) ? $clog2(nr_harts) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ndmreset_i,
  input  logic [hart_bits-1:0] hartsel_i,
  input  logic [nr_harts-1:0]  haltreq_i,
  input  logic [nr_harts-1:0]  resumereq_i,
  input  logic                 cmd_valid_i,
  input  command_t             cmd_i,
  dm_hart_if.ctrl              hart,
  output logic                 go_o,
  output logic                 resume_o,
  output logic                 cmdbusy_o,
  output logic                 cmderror_valid_o,
  output cmderr_e              cmderror_o
);

  // vectors padded to a power of two so any hartsel value indexes safely
  localparam int unsigned harts_al = 2 ** hart_bits;

  typedef enum logic [1:0] {st_idle, st_go, st_resume, st_exec} state_e;

  state_e              state_d, state_q;
  ac_ar_cmd_t          ac_ar;
  logic                unsupported;
  logic [harts_al-1:0] halted_al, resuming_al, halt_evt_al, haltreq_al, resumereq_al;

  assign halted_al    = harts_al'(hart.halted);
  assign resuming_al  = harts_al'(hart.resuming);
  assign halt_evt_al  = harts_al'(hart.halted_evt);
  assign haltreq_al   = harts_al'(haltreq_i);
  assign resumereq_al = harts_al'(resumereq_i);

  // ------------------------------------------------------------------
  // command check, only access register without postincrement
  // ------------------------------------------------------------------
  assign ac_ar       = ac_ar_cmd_t'(cmd_i.control);
  assign unsupported = (cmd_i.cmdtype != access_register) ||
                       (ac_ar.transfer && (ac_ar.regno[15:14] != 2'b00)) ||
                       (32'(ac_ar.aarsize) >= max_aar) ||
                       ac_ar.aarpostincrement;

  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmdbusy_o        = 1'b1;
    cmderror_valid_o = 1'b0;
    cmderror_o       = cmd_err_none;

    unique case (state_q)
      st_idle: begin
        cmdbusy_o = 1'b0;
        if (cmd_valid_i && halted_al[hartsel_i] && !unsupported) begin
          state_d = st_go;
        end else if (cmd_valid_i) begin
          // hart has to be halted for any command
          cmderror_valid_o = 1'b1;
          cmderror_o       = cmd_err_halt_resume;
        end
        // resume only a halted hart that is not asked to halt again
        if (resumereq_al[hartsel_i] && !resuming_al[hartsel_i] &&
            !haltreq_al[hartsel_i] && halted_al[hartsel_i]) begin
          state_d = st_resume;
        end
      end
      st_go: begin
        // hart polls go in the flags, then reports going
        go_o = 1'b1;
        if (hart.going) begin
          state_d = st_exec;
        end
      end
      st_resume: begin
        resume_o = 1'b1;
        if (resuming_al[hartsel_i]) begin
          state_d = st_idle;
        end
      end
      st_exec: begin
        // command done once the hart parks in halted again
        if (halt_evt_al[hartsel_i]) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase

    // later checks win
    if (cmd_valid_i && unsupported) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = cmd_err_not_supported;
    end
    if (hart.exception) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = cmd_err_exception;
    end

    // harts in reset get no go or resume
    if (ndmreset_i) begin
      state_d  = st_idle;
      go_o     = 1'b0;
      resume_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  a_go_resume_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(go_o && resume_o));

  // busy only ends on a halted event, a resuming hart or a non-debug reset
  a_busy_end: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(cmdbusy_o) |->
      $past(halt_evt_al[hartsel_i] || resuming_al[hartsel_i] || ndmreset_i));

endmodule

// ==== rtl/dm_hart_status.sv ====
`timescale 1ns/1ps

module dm_hart_status import dm_mem_pkg::*; #(
  parameter int unsigned  nr_harts  = 2,
  localparam int unsigned hart_bits = (nr_harts > 1) ? $clog2(nr_harts) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ndmreset_i,
  input  logic [hart_bits-1:0] hartsel_i,
  input  logic                 clear_resumeack_i,
  dm_mem_bus_if.target         bus,
  dm_hart_if.status            hart
);

  logic [nr_harts-1:0]  halted_d, halted_q;
  logic [nr_harts-1:0]  resuming_d, resuming_q;
  // notifying hart writes its own index
  logic [hart_bits-1:0] wdata_hart;
  dbg_addr_t            addr;

  assign wdata_hart = bus.wdata[hart_bits-1:0];
  assign addr       = bus.addr[dbg_addr_bits-1:0];

  always_comb begin
    halted_d       = halted_q;
    resuming_d     = resuming_q;
    hart.halted_evt = '0;
    hart.going      = 1'b0;
    hart.exception  = 1'b0;

    // debugger acknowledged the resume
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end

    if (bus.req && bus.we) begin
      unique case (addr)
        halted_addr: begin
          halted_d[wdata_hart]        = 1'b1;
          hart.halted_evt[wdata_hart] = 1'b1;
        end
        going_addr: hart.going = 1'b1;
        resuming_addr: begin
          // hart left debug mode, stays resuming until acked
          halted_d[wdata_hart]   = 1'b0;
          resuming_d[wdata_hart] = 1'b1;
        end
        exception_addr: hart.exception = 1'b1;
        default: ;
      endcase
    end

    // a hart in reset is neither halted nor resuming
    if (ndmreset_i) begin
      halted_d   = '0;
      resuming_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

  assign hart.halted   = halted_q;
  assign hart.resuming = resuming_q;

  // a halted write parks the hart unless it is held in reset
  a_halt_evt_sets: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((hart.halted_evt != '0) && !ndmreset_i) |=>
      ((hart.halted & $past(hart.halted_evt)) != '0));

endmodule

// ==== rtl/dm_data_window.sv ====
`timescale 1ns/1ps

module dm_data_window import dm_mem_pkg::*; (
  dm_mem_bus_if.target           bus,
  input  word_t [data_count-1:0] data_i,
  output word_t [data_count-1:0] data_o,
  output logic                   data_valid_o
);

  dbg_addr_t                addr;
  logic                     in_data;
  logic [data_idx_bits-1:0] idx;

  assign addr    = bus.addr[dbg_addr_bits-1:0];
  assign in_data = (addr >= data_base_addr) && (addr <= data_end_addr);
  // word index inside the data region
  assign idx     = data_idx_bits'(addr[dbg_addr_bits-1:2] - data_base_addr[dbg_addr_bits-1:2]);

  // ------------------------------------------------------------------
  // byte merge, unselected lanes keep the debugger side value
  // ------------------------------------------------------------------
  always_comb begin
    data_o       = data_i;
    data_valid_o = 1'b0;
    if (bus.req && bus.we && in_data) begin
      data_valid_o = 1'b1;
      for (int b = 0; b < bus_width / 8; b++) begin
        if (bus.be[b]) begin
          data_o[idx][8*b +: 8] = bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // the debugger latches data_o whenever valid is high
  always_comb begin
    if (data_valid_o) begin
      a_valid_write: assert (bus.req && bus.we);
    end
  end

endmodule

// ==== rtl/dm_read_mux.sv ====
`timescale 1ns/1ps

module dm_read_mux import dm_mem_pkg::*; #(
  parameter int unsigned  nr_harts  = 2,
  localparam int unsigned hart_bits = (nr_harts > 1) ? $clog2(nr_harts) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [hart_bits-1:0]    hartsel_i,
  input  logic [nr_harts-1:0]     resumereq_i,
  input  logic                    go_i,
  input  logic                    resume_i,
  input  logic                    cmdbusy_i,
  input  command_t                cmd_i,
  input  word_t [data_count-1:0]  data_i,
  input  word_t [progbuf_size-1:0] progbuf_i,
  dm_mem_bus_if.target            bus,
  output word_t                   rdata_o
);

  localparam int unsigned harts_al = 2 ** hart_bits;

  dbg_addr_t           addr;
  dbg_addr_t           hart_off;
  dbg_addr_t           flag_off;
  logic [harts_al-1:0] resumereq_al;
  ac_ar_cmd_t          ac_ar;
  word_t               rdata_d, rdata_q;

  assign addr         = bus.addr[dbg_addr_bits-1:0];
  assign hart_off     = dbg_addr_t'(hartsel_i);
  // word aligned offset into the flags region
  assign flag_off     = {addr[dbg_addr_bits-1:2], 2'b00} - flags_base_addr;
  assign resumereq_al = harts_al'(resumereq_i);
  assign ac_ar        = ac_ar_cmd_t'(cmd_i.control);

  always_comb begin
    // hold the last read value between reads
    rdata_d = rdata_q;
    if (bus.req && !bus.we) begin
      // unmapped and abstract command area read as zero
      rdata_d = '0;
      if (addr == whereto_addr) begin
        // --------------------------------------------------------------
        // whereto, jump target for the hart leaving the park loop
        // --------------------------------------------------------------
        if (resumereq_al[hartsel_i]) begin
          rdata_d = dm_jal(21'(resume_addr) - 21'(whereto_addr));
        end
        // a running command takes priority over resume
        if (cmdbusy_i) begin
          // no transfer with postexec skips straight to the program buffer
          if (cmd_i.cmdtype == access_register && !ac_ar.transfer && ac_ar.postexec) begin
            rdata_d = dm_jal(21'(progbuf_base_addr) - 21'(whereto_addr));
          end else begin
            rdata_d = dm_jal(21'(abs_cmd_base_addr) - 21'(whereto_addr));
          end
        end
      end else if (addr >= data_base_addr && addr <= data_end_addr) begin
        rdata_d = data_i[data_idx_bits'(addr[dbg_addr_bits-1:2] -
                                        data_base_addr[dbg_addr_bits-1:2])];
      end else if (addr >= progbuf_base_addr && addr <= progbuf_end_addr) begin
        rdata_d = progbuf_i[progbuf_idx_bits'(addr[dbg_addr_bits-1:2] -
                                              progbuf_base_addr[dbg_addr_bits-1:2])];
      end else if (addr >= flags_base_addr && addr <= flags_end_addr) begin
        // four harts share a word, one flag byte each
        if (flag_off == (hart_off & ~dbg_addr_t'(3))) begin
          rdata_d[{hart_off[1:0], 3'b000} +: 8] = {6'b0, resume_i, go_i};
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== rtl/dm_mem.sv ====
`timescale 1ns/1ps

module dm_mem import dm_mem_pkg::*; #(
  parameter int unsigned  nr_harts  = 2,
  localparam int unsigned hart_bits = (nr_harts > 1) ? $clog2(nr_harts) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  output logic [nr_harts-1:0]      debug_req_o,
  input  logic                     ndmreset_i,
  input  logic [hart_bits-1:0]     hartsel_i,
  // from the control and status registers
  input  logic [nr_harts-1:0]      haltreq_i,
  input  logic [nr_harts-1:0]      resumereq_i,
  input  logic                     clear_resumeack_i,
  output logic [nr_harts-1:0]      halted_o,
  output logic [nr_harts-1:0]      resuming_o,
  input  word_t [progbuf_size-1:0] progbuf_i,
  input  word_t [data_count-1:0]   data_i,
  output word_t [data_count-1:0]   data_o,
  output logic                     data_valid_o,
  // abstract command interface
  input  logic                     cmd_valid_i,
  input  command_t                 cmd_i,
  output logic                     cmderror_valid_o,
  output cmderr_e                  cmderror_o,
  output logic                     cmdbusy_o,
  // hart memory bus
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [bus_width-1:0]     addr_i,
  input  word_t                    wdata_i,
  input  logic [bus_width/8-1:0]   be_i,
  output word_t                    rdata_o
);

  dm_mem_bus_if             bus ();
  dm_hart_if #(.nr_harts(nr_harts)) hart ();

  logic go, resume, cmdbusy;

  // ------------------------------------------------------------------
  // host side of the bus bundle
  // ------------------------------------------------------------------
  assign bus.req   = req_i;
  assign bus.we    = we_i;
  assign bus.addr  = addr_i;
  assign bus.wdata = wdata_i;
  assign bus.be    = be_i;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;
  assign halted_o    = hart.halted;
  assign resuming_o  = hart.resuming;
  assign cmdbusy_o   = cmdbusy;

  dm_cmd_fsm #(.nr_harts(nr_harts)) u_cmd_fsm (
    .clk_i, .rst_ni, .ndmreset_i, .hartsel_i, .haltreq_i, .resumereq_i,
    .cmd_valid_i, .cmd_i,
    .hart             (hart.ctrl),
    .go_o             (go),
    .resume_o         (resume),
    .cmdbusy_o        (cmdbusy),
    .cmderror_valid_o,
    .cmderror_o
  );

  dm_hart_status #(.nr_harts(nr_harts)) u_hart_status (
    .clk_i, .rst_ni, .ndmreset_i, .hartsel_i, .clear_resumeack_i,
    .bus  (bus.target),
    .hart (hart.status)
  );

  dm_data_window u_data_window (
    .bus (bus.target),
    .data_i, .data_o, .data_valid_o
  );

  dm_read_mux #(.nr_harts(nr_harts)) u_read_mux (
    .clk_i, .rst_ni, .hartsel_i, .resumereq_i,
    .go_i      (go),
    .resume_i  (resume),
    .cmdbusy_i (cmdbusy),
    .cmd_i, .data_i, .progbuf_i,
    .bus       (bus.target),
    .rdata_o
  );

endmodule

// ==== tb/tb_dm_mem_model.svh ====
`ifndef TB_DM_MEM_MODEL_SVH
`define TB_DM_MEM_MODEL_SVH

// ----------------------------------------------------------------------
// random numbers, error handling
// ----------------------------------------------------------------------
logic [31:0] lfsr = 32'h8ba8;

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    r    = {r[30:0], fb};
  end
  return r;
endfunction

task automatic stop_on_error(input string why);
  $display("%s", why);
  $display("TEST FAIL");
  $fatal(1, "run stopped");
endtask

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
    stop_on_error("value mismatch");
  end
endtask

// ----------------------------------------------------------------------
// reference model
// ----------------------------------------------------------------------
logic [nr_harts-1:0] m_halted   = '0;
logic [nr_harts-1:0] m_resuming = '0;

// access register only, no postincrement, size below 3, gpr and csr space
function automatic logic cmd_unsupported(input logic [31:0] c);
  return (c[31:24] != 8'h00) || (c[17] && (c[15:14] != 2'b00)) ||
         (c[22:20] >= 3'd3) || c[19];
endfunction

// jal x0, offset scattered over the J-type immediate fields
function automatic logic [31:0] jal_encode(input int off);
  logic [31:0] ins;
  logic [20:0] imm;
  imm         = off[20:0];
  ins         = 32'h0000_006f;
  ins[31]     = imm[20];
  ins[30:21]  = imm[10:1];
  ins[20]     = imm[11];
  ins[19:12]  = imm[19:12];
  return ins;
endfunction

function automatic logic [31:0] whereto_word(input logic busy, input logic resume_req,
                                             input logic [31:0] c);
  logic [31:0] w;
  w = '0;
  if (busy) begin
    // postexec without transfer jumps right into the program buffer
    if (c[31:24] == 8'h00 && !c[17] && c[18]) begin
      w = jal_encode(int'(progbuf_base_addr) - int'(whereto_addr));
    end else begin
      w = jal_encode(int'(abs_cmd_base_addr) - int'(whereto_addr));
    end
  end else if (resume_req) begin
    w = jal_encode(int'(resume_addr) - int'(whereto_addr));
  end
  return w;
endfunction

// one flag byte per hart, four harts to a word
function automatic logic [31:0] flags_word(input logic [31:0] a, input int hart,
                                           input logic go, input logic resume);
  logic [31:0] w;
  int          off;
  w   = '0;
  off = int'(a) - int'(flags_base_addr);
  if (off >= 0 && off < 'h400 && (off & ~3) == (hart & ~3)) begin
    w[8*(hart%4) +: 8] = {6'b0, resume, go};
  end
  return w;
endfunction

// ----------------------------------------------------------------------
// bus and control tasks
// ----------------------------------------------------------------------
word_t [data_count-1:0] wr_data;
logic                   wr_valid;
logic                   wr_err_valid;
logic [2:0]             wr_err;

// one write cycle, combinational outputs captured mid cycle
task automatic bus_write(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] be);
  @(negedge clk_i);
  req_i   = 1'b1;
  we_i    = 1'b1;
  addr_i  = a;
  wdata_i = wd;
  be_i    = be;
  #1;
  wr_data      = data_o;
  wr_valid     = data_valid_o;
  wr_err_valid = cmderror_valid_o;
  wr_err       = cmderror_o;
  @(negedge clk_i);
  req_i = 1'b0;
  we_i  = 1'b0;
endtask

// read data is registered, valid one edge later
task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
  @(negedge clk_i);
  req_i  = 1'b1;
  we_i   = 1'b0;
  addr_i = a;
  @(negedge clk_i);
  req_i = 1'b0;
  d     = rdata_o;
endtask

// hart notification plus model update
task automatic notify_write(input logic [31:0] a, input logic [31:0] wd);
  int h;
  // two harts, so the index is the low bit
  h = int'(wd[0]);
  bus_write(a, wd, 4'hf);
  if (a == 32'(halted_addr)) begin
    m_halted[h] = 1'b1;
  end else if (a == 32'(resuming_addr)) begin
    m_halted[h]   = 1'b0;
    m_resuming[h] = 1'b1;
  end
endtask

task automatic ack_resume(input int h);
  @(negedge clk_i);
  hartsel_i         = 1'(h);
  clear_resumeack_i = 1'b1;
  @(negedge clk_i);
  clear_resumeack_i = 1'b0;
  m_resuming[h]     = 1'b0;
endtask

task automatic wait_not_busy();
  int n;
  n = 0;
  while (cmdbusy_o && n < 50) begin
    @(negedge clk_i);
    n++;
  end
  if (cmdbusy_o) begin
    stop_on_error("timeout, cmdbusy_o still high after 50 cycles");
  end
endtask

`endif

// ==== tb/tb_dm_mem.sv ====
`timescale 1ns/1ps

module tb_dm_mem import dm_mem_pkg::*; ();

  localparam int unsigned nr_harts = 2;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     ndmreset_i;
  logic [0:0]               hartsel_i;
  logic [nr_harts-1:0]      haltreq_i;
  logic [nr_harts-1:0]      resumereq_i;
  logic                     clear_resumeack_i;
  logic [nr_harts-1:0]      debug_req_o;
  logic [nr_harts-1:0]      halted_o;
  logic [nr_harts-1:0]      resuming_o;
  word_t [progbuf_size-1:0] progbuf_i;
  word_t [data_count-1:0]   data_i;
  word_t [data_count-1:0]   data_o;
  logic                     data_valid_o;
  logic                     cmd_valid_i;
  command_t                 cmd_i;
  logic                     cmderror_valid_o;
  cmderr_e                  cmderror_o;
  logic                     cmdbusy_o;
  logic                     req_i;
  logic                     we_i;
  logic [31:0]              addr_i;
  word_t                    wdata_i;
  logic [3:0]               be_i;
  word_t                    rdata_o;

  logic                     cmd_err_valid;
  logic [2:0]               cmd_err;

  `include "tb_dm_mem_model.svh"

  dm_mem #(.nr_harts(nr_harts)) i_dut (.*);

  always #4 clk_i = ~clk_i;

  // halt request is a straight wire to the harts
  always @(posedge clk_i) begin
    check_eq("debug_req_o", 32'(debug_req_o), 32'(haltreq_i));
  end

  // single cycle command strobe, error outputs captured mid cycle
  task automatic issue_cmd(input logic [31:0] c);
    @(negedge clk_i);
    cmd_i       = command_t'(c);
    cmd_valid_i = 1'b1;
    #1;
    cmd_err_valid = cmderror_valid_o;
    cmd_err       = cmderror_o;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  // full command flow on hart 0, go then going then halted
  task automatic run_command(input logic [31:0] c, input logic raise_exc);
    logic [31:0] got;
    issue_cmd(c);
    check_eq("cmderror_valid_o", 32'(cmd_err_valid), 32'd0);
    check_eq("cmdbusy_o", 32'(cmdbusy_o), 32'd1);
    bus_read(32'(flags_base_addr), got);
    check_eq("flags", got, flags_word(32'(flags_base_addr), 0, 1'b1, 1'b0));
    // go is up, yet the next flags word holds no flag of hart 0
    bus_read(32'(flags_base_addr) + 32'd4, got);
    check_eq("flags next word", got, flags_word(32'(flags_base_addr) + 32'd4, 0, 1'b1, 1'b0));
    bus_read(32'(whereto_addr), got);
    check_eq("whereto", got, whereto_word(1'b1, resumereq_i[0], c));
    notify_write(32'(going_addr), 32'd0);
    if (raise_exc) begin
      notify_write(32'(exception_addr), 32'd0);
      check_eq("cmderror_valid_o", 32'(wr_err_valid), 32'd1);
      check_eq("cmderror_o", 32'(wr_err), 32'(cmd_err_exception));
    end
    notify_write(32'(halted_addr), 32'd0);
    wait_not_busy();
    check_eq("halted_o", 32'(halted_o), 32'(m_halted));
  endtask

  initial begin : stimulus
    logic [31:0]            rnd;
    logic [31:0]            wd;
    logic [31:0]            got;
    logic [31:0]            c;
    logic [3:0]             be;
    int                     idx;
    word_t [data_count-1:0] exp_data;

    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    ndmreset_i        = 1'b0;
    hartsel_i         = '0;
    haltreq_i         = '0;
    resumereq_i       = '0;
    clear_resumeack_i = 1'b0;
    progbuf_i         = '0;
    data_i            = '0;
    cmd_valid_i       = 1'b0;
    cmd_i             = '0;
    req_i             = 1'b0;
    we_i              = 1'b0;
    addr_i            = '0;
    wdata_i           = '0;
    be_i              = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // ------------------------------------------------------------------
    // reset values
    // ------------------------------------------------------------------
    check_eq("cmdbusy_o", 32'(cmdbusy_o), 32'd0);
    check_eq("halted_o", 32'(halted_o), 32'd0);
    check_eq("resuming_o", 32'(resuming_o), 32'd0);
    check_eq("rdata_o", rdata_o, 32'd0);
    check_eq("data_valid_o", 32'(data_valid_o), 32'd0);
    check_eq("cmderror_valid_o", 32'(cmderror_valid_o), 32'd0);

    // ------------------------------------------------------------------
    // notification writes for random harts
    // ------------------------------------------------------------------
    for (int i = 0; i < 16; i++) begin
      rnd       = rand_bits(2);
      haltreq_i = 2'(rand_bits(2));
      case (rnd[1:0])
        2'd0: notify_write(32'(halted_addr), rand_bits(32));
        2'd1: notify_write(32'(resuming_addr), rand_bits(32));
        default: ack_resume(int'(rand_bits(1)));
      endcase
      check_eq("halted_o", 32'(halted_o), 32'(m_halted));
      check_eq("resuming_o", 32'(resuming_o), 32'(m_resuming));
    end
    notify_write(32'(halted_addr), 32'd1);
    notify_write(32'(resuming_addr), 32'd0);
    // non-debug reset wipes both vectors
    @(negedge clk_i);
    ndmreset_i = 1'b1;
    haltreq_i  = '0;
    @(negedge clk_i);
    ndmreset_i = 1'b0;
    m_halted   = '0;
    m_resuming = '0;
    check_eq("halted_o", 32'(halted_o), 32'd0);
    check_eq("resuming_o", 32'(resuming_o), 32'd0);

    // ------------------------------------------------------------------
    // data registers and program buffer
    // ------------------------------------------------------------------
    for (int k = 0; k < data_count; k++) begin
      data_i[k] = rand_bits(32);
    end
    for (int k = 0; k < progbuf_size; k++) begin
      progbuf_i[k] = rand_bits(32);
    end
    for (int i = 0; i < 12; i++) begin
      idx      = int'(rand_bits(1));
      wd       = rand_bits(32);
      be       = 4'(rand_bits(4));
      exp_data = data_i;
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          exp_data[idx][8*b +: 8] = wd[8*b +: 8];
        end
      end
      bus_write(32'(data_base_addr) + 32'(4 * idx), wd, be);
      check_eq("data_valid_o", 32'(wr_valid), 32'd1);
      for (int k = 0; k < data_count; k++) begin
        check_eq($sformatf("data_o[%0d]", k), wr_data[k], exp_data[k]);
      end
    end
    // writes outside the data region leave data_o alone
    bus_write(32'(progbuf_base_addr), rand_bits(32), 4'hf);
    check_eq("data_valid_o", 32'(wr_valid), 32'd0);
    check_eq("data_o[0]", wr_data[0], data_i[0]);
    for (int k = 0; k < data_count; k++) begin
      bus_read(32'(data_base_addr) + 32'(4 * k), got);
      check_eq($sformatf("rdata_o data %0d", k), got, data_i[k]);
    end
    for (int k = 0; k < progbuf_size; k++) begin
      bus_read(32'(progbuf_base_addr) + 32'(4 * k), got);
      check_eq($sformatf("rdata_o progbuf %0d", k), got, progbuf_i[k]);
    end
    bus_read(32'(abs_cmd_base_addr), got);
    check_eq("rdata_o abstract area", got, 32'd0);
    bus_read(32'h0000_0200, got);
    check_eq("rdata_o unmapped", got, 32'd0);

    // ------------------------------------------------------------------
    // abstract commands on hart 0
    // ------------------------------------------------------------------
    @(negedge clk_i);
    hartsel_i = 1'b0;
    issue_cmd(32'h0022_1000);
    check_eq("cmderror_valid_o", 32'(cmd_err_valid), 32'd1);
    check_eq("cmderror_o", 32'(cmd_err), 32'(cmd_err_halt_resume));
    check_eq("cmdbusy_o", 32'(cmdbusy_o), 32'd0);
    notify_write(32'(halted_addr), 32'd0);
    for (int i = 0; i < 6; i++) begin
      c = rand_bits(32);
      // force postincrement when the draw happens to be legal
      if (!cmd_unsupported(c)) begin
        c[19] = 1'b1;
      end
      issue_cmd(c);
      check_eq("cmderror_valid_o", 32'(cmd_err_valid), 32'd1);
      check_eq("cmderror_o", 32'(cmd_err), 32'(cmd_err_not_supported));
      check_eq("cmdbusy_o", 32'(cmdbusy_o), 32'd0);
    end
    // transfer set, so whereto points at the abstract area
    run_command(32'h0022_1000, 1'b0);
    // postexec only, whereto points at the program buffer
    run_command(32'h0024_0000, 1'b1);

    // ------------------------------------------------------------------
    // resume of hart 0
    // ------------------------------------------------------------------
    @(negedge clk_i);
    resumereq_i = 2'b01;
    bus_read(32'(flags_base_addr), got);
    check_eq("flags", got, flags_word(32'(flags_base_addr), 0, 1'b0, 1'b1));
    check_eq("cmdbusy_o", 32'(cmdbusy_o), 32'd1);
    notify_write(32'(resuming_addr), 32'd0);
    wait_not_busy();
    check_eq("halted_o", 32'(halted_o), 32'(m_halted));
    check_eq("resuming_o", 32'(resuming_o), 32'(m_resuming));
    bus_read(32'(whereto_addr), got);
    check_eq("whereto", got, whereto_word(1'b0, 1'b1, 32'(cmd_i)));
    ack_resume(0);
    @(negedge clk_i);
    resumereq_i = '0;
    check_eq("resuming_o", 32'(resuming_o), 32'(m_resuming));
    bus_read(32'(whereto_addr), got);
    check_eq("whereto", got, 32'd0);

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tb
rtl/dm_mem_pkg.sv
rtl/dm_mem_bus_if.sv
rtl/dm_hart_if.sv
rtl/dm_cmd_fsm.sv
rtl/dm_hart_status.sv
rtl/dm_data_window.sv
rtl/dm_read_mux.sv
rtl/dm_mem.sv
tb/tb_dm_mem.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is nonzero on a build error or a failing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_dm_mem \
  -f filelist.f \
  -o sim_tb_dm_mem
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb_dm_mem
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished cleanly"
exit 0
